/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass or fail comes from the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module tb_upload_ram \
   -f upload_ram.f --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_upload_ram > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi
exit 0

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
   parameter int half_period  = 5,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst
);
   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // reset drops 1 ns after the last reset edge
   initial begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

/* test/tb_upload_ram.sv */
`timescale 1ns/1ps

module tb_upload_ram;
   import layout_pkg::*;
   import slot_pkg::*;

   localparam int num_tests  = 2;
   localparam int page_bytes = 16;
   localparam int timeout    = 5000;

   logic clk, rst, update_request, update_ack, busy;
   logic ddr3_ready, ddr3_rd, sdram_ready, sdram_we, rd_init;
   logic [7:0] ddr3_dout, sdram_din;
   cfg_index_t cfg_index;
   config_typ_t cfg_typ;
   slot_sel_t cfg_slot, cfg_subslot, cfg_page, cfg_ref_page;
   slot_sel_t rd_slot, rd_subslot, rd_page, rd_offset;
   block_count_t cfg_block_count, ram_mapper_count, blk_rd_count;
   ddr3_addr_t cfg_store_addr, ddr3_addr, rd_addr;
   sdram_addr_t sdram_addr, blk_rd_offset;
   slot_typ_t rd_typ, rd_slot_typ;
   block_id_t rd_block_id, blk_rd_id;

   // configuration lists, one row per test
   config_typ_t tab_typ [num_tests][max_config];
   slot_sel_t tab_slot [num_tests][max_config];
   slot_sel_t tab_sub [num_tests][max_config];
   slot_sel_t tab_page [num_tests][max_config];
   slot_sel_t tab_ref [num_tests][max_config];
   block_count_t tab_count [num_tests][max_config];
   ddr3_addr_t tab_store [num_tests][max_config];
   // the expected slot map is indexed by slot * 16 + subslot * 4 + page
   slot_typ_t exp_typ [num_tests][64];
   block_id_t exp_id [num_tests][64];
   slot_sel_t exp_off [num_tests][64];
   logic exp_init [num_tests][64];
   slot_typ_t exp_slot_typ [num_tests][4];

   sdram_addr_t wr_addr_q [$];
   logic [7:0] wr_data_q [$];
   int seed = 55;
   int lat;
   int cur_test;
   int errors;
   int timeouts;

   tb_clock u_clock (.clk(clk), .rst(rst));

   upload_ram #(.block_bits(4)) dut (.*);

   // the configuration list answers combinationally from cfg_index
   always_comb begin
      cfg_typ         = tab_typ[cur_test][cfg_index];
      cfg_slot        = tab_slot[cur_test][cfg_index];
      cfg_subslot     = tab_sub[cur_test][cfg_index];
      cfg_page        = tab_page[cur_test][cfg_index];
      cfg_ref_page    = tab_ref[cur_test][cfg_index];
      cfg_block_count = tab_count[cur_test][cfg_index];
      cfg_store_addr  = tab_store[cur_test][cfg_index];
   end

   // DDR3 model with a random read latency of 1 to 4 cycles
   initial begin
      ddr3_ready = 1'b1;
      ddr3_dout  = 8'h00;
      forever begin
         @(negedge clk);
         if (ddr3_rd) begin
            rd_addr = ddr3_addr;
            lat = ($random(seed) & 3) + 1;
            @(posedge clk);
            #1 ddr3_ready = 1'b0;
            repeat (lat) @(posedge clk);
            #1;
            ddr3_dout  = rd_addr[7:0] ^ 8'h5A;
            ddr3_ready = 1'b1;
         end
      end
   end

   // the SDRAM model drops ready about one cycle in three
   initial begin
      sdram_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1 sdram_ready = ($random(seed) % 3) != 0;
      end
   end

   always @(negedge clk) begin
      if (sdram_we) begin
         wr_addr_q.push_back(sdram_addr);
         wr_data_q.push_back(sdram_din);
      end
      if (ddr3_rd && !ddr3_ready) begin
         errors++;
         $display("DDR3 read strobe raised while ddr3_ready was low");
      end
      if (sdram_we && !sdram_ready) begin
         errors++;
         $display("SDRAM write strobe raised while sdram_ready was low");
      end
   end

   task automatic compare_typ(input string name, input slot_typ_t exp, input slot_typ_t act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic compare_id(input string name, input block_id_t exp, input block_id_t act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic compare_addr(input string name, input sdram_addr_t exp, input sdram_addr_t act);
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected 'h%0h, actual 'h%0h", name, exp, act);
      end
   endtask

   task automatic add_entry(input int t, input int i, input config_typ_t typ, input int slot,
                            input int sub, input int page, input int refp, input int count,
                            input ddr3_addr_t store);
      tab_typ[t][i]   = typ;
      tab_slot[t][i]  = slot_sel_t'(slot);
      tab_sub[t][i]   = slot_sel_t'(sub);
      tab_page[t][i]  = slot_sel_t'(page);
      tab_ref[t][i]   = slot_sel_t'(refp);
      tab_count[t][i] = block_count_t'(count);
      tab_store[t][i] = store;
   endtask

   task automatic expect_page(input int t, input int slot, input int sub, input int page,
                              input slot_typ_t typ, input int id, input int off);
      exp_typ[t][slot * 16 + sub * 4 + page]  = typ;
      exp_id[t][slot * 16 + sub * 4 + page]   = block_id_t'(id);
      exp_off[t][slot * 16 + sub * 4 + page]  = slot_sel_t'(off);
      exp_init[t][slot * 16 + sub * 4 + page] = 1'b1;
   endtask

   task automatic load_table();
      for (int t = 0; t < num_tests; t++) begin
         for (int i = 0; i < max_config; i++) add_entry(t, i, CONFIG_NONE, 0, 0, 0, 0, 0, '0);
         for (int p = 0; p < 64; p++) begin
            exp_typ[t][p]  = SLOT_TYP_EMPTY;
            exp_init[t][p] = 1'b0;
         end
         for (int s = 0; s < 4; s++) exp_slot_typ[t][s] = SLOT_TYP_EMPTY;
      end
      // BIOS, RAM, a subslot mapper, then a mirror after some empty entries
      add_entry(0, 0, CONFIG_BIOS, 0, 0, 0, 0, 2, 28'h0000100);
      add_entry(0, 1, CONFIG_RAM, 3, 0, 2, 0, 2, '0);
      add_entry(0, 2, CONFIG_RAM_MAPPER, 1, 2, 0, 0, 3, '0);
      add_entry(0, 5, CONFIG_MIRROR, 0, 0, 3, 0, 1, '0);
      // a later RAM page in the BIOS slot leaves the slot type at ROM
      add_entry(0, 6, CONFIG_RAM, 0, 0, 2, 0, 1, '0);
      expect_page(0, 0, 0, 0, SLOT_TYP_ROM, 0, 0);
      expect_page(0, 0, 0, 1, SLOT_TYP_ROM, 0, 1);
      expect_page(0, 0, 0, 3, SLOT_TYP_ROM, 0, 0);
      expect_page(0, 0, 0, 2, SLOT_TYP_RAM, 3, 0);
      expect_page(0, 3, 0, 2, SLOT_TYP_RAM, 1, 0);
      expect_page(0, 3, 0, 3, SLOT_TYP_RAM, 1, 1);
      for (int p = 0; p < 3; p++) expect_page(0, 1, 2, p, SLOT_TYP_MSX2_RAM, 2, p);
      exp_slot_typ[0][0] = SLOT_TYP_ROM;
      exp_slot_typ[0][1] = SLOT_TYP_MAPPER;
      exp_slot_typ[0][3] = SLOT_TYP_RAM;
      // the last entry of the list runs past page 3 and is cut there
      add_entry(1, 0, CONFIG_RAM, 2, 0, 1, 0, 1, '0);
      add_entry(1, 1, CONFIG_BIOS, 2, 1, 2, 0, 1, 28'h0ABCDE0);
      add_entry(1, 2, CONFIG_MIRROR, 2, 1, 3, 2, 1, '0);
      add_entry(1, 3, CONFIG_RAM_MAPPER, 3, 0, 0, 0, 4, '0);
      add_entry(1, 15, CONFIG_RAM, 0, 3, 3, 0, 2, '0);
      expect_page(1, 2, 0, 1, SLOT_TYP_RAM, 0, 0);
      expect_page(1, 2, 1, 2, SLOT_TYP_ROM, 1, 0);
      expect_page(1, 2, 1, 3, SLOT_TYP_ROM, 1, 0);
      for (int p = 0; p < 4; p++) expect_page(1, 3, 0, p, SLOT_TYP_MSX2_RAM, 2, p);
      expect_page(1, 0, 3, 3, SLOT_TYP_RAM, 3, 0);
      exp_slot_typ[1][0] = SLOT_TYP_MAPPER;
      exp_slot_typ[1][2] = SLOT_TYP_MAPPER;
      exp_slot_typ[1][3] = SLOT_TYP_MSX2_RAM;
   endtask

   task automatic verify_slot_map(input int t);
      string tag;
      for (int p = 0; p < 64; p++) begin
         @(posedge clk);
         #1;
         rd_slot    = slot_sel_t'(p >> 4);
         rd_subslot = slot_sel_t'(p >> 2);
         rd_page    = slot_sel_t'(p);
         @(negedge clk);
         tag = $sformatf("test %0d map %0d.%0d.%0d", t, p >> 4, (p >> 2) & 3, p & 3);
         compare_addr({tag, " init"}, sdram_addr_t'(exp_init[t][p]), sdram_addr_t'(rd_init));
         compare_typ({tag, " type"}, exp_typ[t][p], rd_typ);
         if (exp_init[t][p]) begin
            compare_id({tag, " block"}, exp_id[t][p], rd_block_id);
            compare_addr({tag, " offset"}, sdram_addr_t'(exp_off[t][p]), sdram_addr_t'(rd_offset));
         end
         if ((p & 15) == 0) begin
            compare_typ($sformatf("test %0d slot %0d type", t, p >> 4), exp_slot_typ[t][p >> 4],
                        rd_slot_typ);
         end
      end
   endtask

   task automatic verify_blocks(input int t);
      int id;
      int start;
      int k;
      int nbytes;
      config_typ_t typ;
      block_count_t map_count;
      ddr3_addr_t src;
      logic [7:0] exp_byte;
      id        = 0;
      start     = 0;
      k         = 0;
      map_count = '0;
      for (int e = 0; e < max_config; e++) begin
         typ = tab_typ[t][e];
         if (typ inside {CONFIG_BIOS, CONFIG_RAM, CONFIG_RAM_MAPPER} && tab_count[t][e] != '0) begin
            @(posedge clk);
            #1 blk_rd_id = block_id_t'(id);
            @(negedge clk);
            compare_addr($sformatf("test %0d block %0d count", t, id),
                         sdram_addr_t'(tab_count[t][e]), sdram_addr_t'(blk_rd_count));
            compare_addr($sformatf("test %0d block %0d start", t, id), sdram_addr_t'(start),
                         blk_rd_offset);
            nbytes = tab_count[t][e] * page_bytes;
            for (int b = 0; b < nbytes; b++) begin
               src      = tab_store[t][e] + ddr3_addr_t'(b);
               exp_byte = (typ == CONFIG_BIOS) ? (src[7:0] ^ 8'h5A) : 8'h00;
               if (k < wr_addr_q.size()) begin
                  compare_addr($sformatf("test %0d write %0d addr", t, k),
                               sdram_addr_t'(start + b), wr_addr_q[k]);
                  compare_addr($sformatf("test %0d write %0d data", t, k),
                               sdram_addr_t'(exp_byte), sdram_addr_t'(wr_data_q[k]));
               end
               k++;
            end
            if (typ == CONFIG_RAM_MAPPER) map_count = tab_count[t][e];
            start += nbytes;
            id++;
         end
      end
      if (k != wr_addr_q.size()) begin
         errors++;
         $display("test %0d: %0d SDRAM writes seen where %0d were expected", t,
                  wr_addr_q.size(), k);
      end
      compare_addr($sformatf("test %0d mapper count", t), sdram_addr_t'(map_count),
                   sdram_addr_t'(ram_mapper_count));
   endtask

   task automatic run_test(input int t);
      int n;
      cur_test = t;
      wr_addr_q.delete();
      wr_data_q.delete();
      @(posedge clk);
      #1 update_request = 1'b1;
      @(posedge clk);
      #1 update_request = 1'b0;
      @(negedge clk);
      compare_addr($sformatf("test %0d busy after request", t), 1, sdram_addr_t'(busy));
      compare_addr($sformatf("test %0d ack after request", t), 1, sdram_addr_t'(update_ack));
      @(negedge clk);
      compare_addr($sformatf("test %0d ack one cycle", t), 0, sdram_addr_t'(update_ack));
      for (n = 0; n < timeout && busy; n++) @(negedge clk);
      if (busy) begin
         timeouts++;
         $display("test %0d: busy still high after %0d cycles", t, timeout);
      end else begin
         verify_slot_map(t);
         verify_blocks(t);
      end
   endtask

   initial begin
      errors         = 0;
      timeouts       = 0;
      cur_test       = 0;
      update_request = 1'b0;
      rd_slot        = '0;
      rd_subslot     = '0;
      rd_page        = '0;
      blk_rd_id      = '0;
      load_table();
      for (int n = 0; n < 20 && rst !== 1'b0; n++) @(negedge clk);
      if (rst !== 1'b0) begin
         timeouts++;
         $display("reset was never released");
      end
      for (int n = 0; n < 5; n++) begin
         @(negedge clk);
         compare_addr("idle busy", 0, sdram_addr_t'(busy));
         compare_addr("idle ack", 0, sdram_addr_t'(update_ack));
         compare_addr("idle ddr3_rd", 0, sdram_addr_t'(ddr3_rd));
         compare_addr("idle sdram_we", 0, sdram_addr_t'(sdram_we));
      end
      for (int t = 0; t < num_tests && timeouts == 0; t++) run_test(t);
      $display("error count %0d, timeout count %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* upload_ram.f */
verilog/layout_pkg.sv
verilog/slot_pkg.sv
verilog/byte_counter.sv
verilog/slot_table.sv
verilog/block_table.sv
verilog/upload_fsm.sv
verilog/upload_ram.sv
test/tb_clock.sv
test/tb_upload_ram.sv

/* verilog/block_table.sv */
`timescale 1ns/1ps

module block_table (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     blk_clear,
   input  logic                     blk_start,
   input  layout_pkg::block_count_t blk_count,
   input  logic                     blk_write_step,
   output slot_pkg::block_id_t      cur_block_id,
   output slot_pkg::sdram_addr_t    write_addr,
   input  slot_pkg::block_id_t      rd_id,
   output layout_pkg::block_count_t rd_count,
   output slot_pkg::sdram_addr_t    rd_offset
);
   import layout_pkg::*;
   import slot_pkg::*;

   localparam int num_blocks = 2 ** $bits(block_id_t);

   block_id_t    next_id;
   sdram_addr_t  write_ptr;
   block_count_t count_mem [num_blocks];
   sdram_addr_t  start_mem [num_blocks];

   always_ff @(posedge clk) begin
      if (rst || blk_clear) begin
         next_id   <= '0;
         write_ptr <= '0;
      end else begin
         if (blk_start) next_id <= next_id + 1'b1;
         if (blk_write_step) write_ptr <= write_ptr + 1'b1;
      end
   end

   // a block starts where the previous one stopped writing
   always_ff @(posedge clk) begin
      if (blk_start) begin
         count_mem[next_id] <= blk_count;
         start_mem[next_id] <= write_ptr;
      end
   end

   assign cur_block_id = next_id;
   assign write_addr   = write_ptr;
   assign rd_count     = count_mem[rd_id];
   assign rd_offset    = start_mem[rd_id];

endmodule

/* verilog/byte_counter.sv */
`timescale 1ns/1ps

module byte_counter #(
   parameter int block_bits = 14
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     count_clear,
   input  logic                     count_step,
   input  layout_pkg::block_count_t count_limit,
   output logic [23:0]              count_value,
   output logic                     count_last
);
   logic [23:0] target;
   logic [23:0] next_value;

   assign next_value = count_value + 24'd1;

   always_ff @(posedge clk) begin
      if (rst) begin
         count_value <= '0;
         count_last  <= 1'b0;
         target      <= '0;
      end else if (count_clear) begin
         count_value <= '0;
         count_last  <= 1'b0;
         // a zero limit selects the sweep over the 64 slot-map entries
         target      <= (count_limit == '0) ? 24'd64 : 24'(count_limit) << block_bits;
      end else if (count_step) begin
         count_value <= next_value;
         count_last  <= next_value == target;
      end
   end

endmodule

/* verilog/layout_pkg.sv */
package layout_pkg;

   // kind of one entry in the configuration list
   typedef enum logic [2:0] {
      CONFIG_NONE,
      CONFIG_BIOS,
      CONFIG_RAM,
      CONFIG_RAM_MAPPER,
      CONFIG_MIRROR
   } config_typ_t;

   // index into the configuration list
   typedef logic [3:0] cfg_index_t;

   // byte address on the DDR3 side
   typedef logic [27:0] ddr3_addr_t;

   // number of pages in one block
   typedef logic [7:0] block_count_t;

   localparam int max_config = 16;

endpackage

/* verilog/slot_pkg.sv */
package slot_pkg;

   // what a slot or a single page of the map holds
   typedef enum logic [2:0] {
      SLOT_TYP_EMPTY,
      SLOT_TYP_ROM,
      SLOT_TYP_RAM,
      SLOT_TYP_MSX2_RAM,
      SLOT_TYP_MAPPER
   } slot_typ_t;

   // slot, subslot, page and page offset are all 2 bits
   typedef logic [1:0] slot_sel_t;

   typedef logic [3:0] block_id_t;

   // byte address on the SDRAM side
   typedef logic [24:0] sdram_addr_t;

   // flat {slot, subslot, page} index of a slot-map entry
   typedef logic [5:0] init_ptr_t;

endpackage

/* verilog/slot_table.sv */
`timescale 1ns/1ps

module slot_table (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     slot_clear,
   input  slot_pkg::init_ptr_t      clear_index,
   input  logic                     slot_fill,
   input  slot_pkg::slot_sel_t      fill_slot,
   input  slot_pkg::slot_sel_t      fill_subslot,
   input  slot_pkg::slot_sel_t      fill_page,
   input  layout_pkg::block_count_t fill_count,
   input  slot_pkg::slot_typ_t      fill_typ,
   input  slot_pkg::block_id_t      fill_block_id,
   input  slot_pkg::slot_sel_t      ref_page,
   output slot_pkg::block_id_t      ref_block_id,
   output slot_pkg::slot_typ_t      ref_typ,
   input  slot_pkg::slot_sel_t      rd_slot,
   input  slot_pkg::slot_sel_t      rd_subslot,
   input  slot_pkg::slot_sel_t      rd_page,
   output slot_pkg::slot_typ_t      rd_typ,
   output slot_pkg::block_id_t      rd_block_id,
   output slot_pkg::slot_sel_t      rd_offset,
   output logic                     rd_init,
   output slot_pkg::slot_typ_t      rd_slot_typ
);
   import layout_pkg::*;
   import slot_pkg::*;

   slot_typ_t typ_mem    [64];
   block_id_t id_mem     [64];
   slot_sel_t offset_mem [64];
   logic      [63:0] init_q;
   slot_typ_t slot_typ_q [4];

   logic      [2:0] page_sum [4];
   logic      [3:0] fill_en;
   init_ptr_t fill_ptr   [4];
   init_ptr_t ref_ptr;
   init_ptr_t rd_ptr;

   // a fill covers up to four pages and never runs past page 3
   for (genvar g = 0; g < 4; g++) begin : g_fill
      assign page_sum[g] = {1'b0, fill_page} + 3'(g);
      assign fill_en[g]  = slot_fill && !page_sum[g][2] && fill_count > block_count_t'(g);
      assign fill_ptr[g] = {fill_slot, fill_subslot, page_sum[g][1:0]};
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         init_q     <= '0;
         slot_typ_q <= '{default: SLOT_TYP_EMPTY};
      end else if (slot_clear) begin
         init_q[clear_index]          <= 1'b0;
         slot_typ_q[clear_index[5:4]] <= SLOT_TYP_EMPTY;
      end else if (slot_fill) begin
         for (int i = 0; i < 4; i++) begin
            if (fill_en[i]) init_q[fill_ptr[i]] <= 1'b1;
         end
         // the first fill of a slot names it, any subslot use turns it into an expander
         if (slot_typ_q[fill_slot] == SLOT_TYP_EMPTY) slot_typ_q[fill_slot] <= fill_typ;
         if (fill_subslot != '0) slot_typ_q[fill_slot] <= SLOT_TYP_MAPPER;
      end
   end

   always_ff @(posedge clk) begin
      if (slot_clear) typ_mem[clear_index] <= SLOT_TYP_EMPTY;
      for (int i = 0; i < 4; i++) begin
         if (fill_en[i]) begin
            typ_mem[fill_ptr[i]]    <= fill_typ;
            id_mem[fill_ptr[i]]     <= fill_block_id;
            offset_mem[fill_ptr[i]] <= slot_sel_t'(i);
         end
      end
   end

   // mirror lookup stays inside the slot and subslot being filled
   assign ref_ptr      = {fill_slot, fill_subslot, ref_page};
   assign ref_block_id = id_mem[ref_ptr];
   assign ref_typ      = typ_mem[ref_ptr];

   assign rd_ptr      = {rd_slot, rd_subslot, rd_page};
   assign rd_typ      = typ_mem[rd_ptr];
   assign rd_block_id = id_mem[rd_ptr];
   assign rd_offset   = offset_mem[rd_ptr];
   assign rd_init     = init_q[rd_ptr];
   assign rd_slot_typ = slot_typ_q[rd_slot];

endmodule

/* verilog/upload_fsm.sv */
`timescale 1ns/1ps

module upload_fsm #(
   parameter int max_config = layout_pkg::max_config
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     update_request,
   output logic                     busy,
   output logic                     update_ack,
   output layout_pkg::cfg_index_t   cfg_index,
   input  layout_pkg::config_typ_t  cfg_typ,
   input  layout_pkg::block_count_t cfg_block_count,
   input  layout_pkg::ddr3_addr_t   cfg_store_addr,
   input  logic                     ddr3_ready,
   output logic                     ddr3_rd,
   output layout_pkg::ddr3_addr_t   ddr3_addr,
   input  logic [7:0]               ddr3_dout,
   input  logic                     sdram_ready,
   output logic                     sdram_we,
   output logic [7:0]               sdram_din,
   output logic                     count_clear,
   output logic                     count_step,
   input  logic                     count_last,
   input  logic [23:0]              count_value,
   output logic                     slot_clear,
   output logic                     slot_fill,
   output slot_pkg::slot_typ_t      fill_typ,
   output slot_pkg::block_id_t      fill_block_id,
   input  slot_pkg::block_id_t      ref_block_id,
   input  slot_pkg::slot_typ_t      ref_typ,
   output logic                     blk_start,
   output logic                     blk_write_step,
   input  slot_pkg::block_id_t      cur_block_id,
   output layout_pkg::block_count_t ram_mapper_count
);
   import layout_pkg::*;
   import slot_pkg::*;

   typedef enum logic [2:0] {
      STATE_WAIT,
      STATE_INIT_SLOT,
      STATE_FILL_SLOT,
      STATE_UPLOAD,
      STATE_FILL_NEXT
   } state_t;

   state_t state;
   logic   rd_wait;
   logic   wr_pending;
   logic   is_mirror;
   logic   is_block;
   logic   is_rom;
   logic   block_go;

   assign is_mirror = cfg_typ == CONFIG_MIRROR;
   assign is_rom    = cfg_typ == CONFIG_BIOS;
   // entries with no pages allocate nothing and are passed over
   assign is_block  = (is_rom || cfg_typ == CONFIG_RAM || cfg_typ == CONFIG_RAM_MAPPER) &&
                      cfg_block_count != '0;

   // a ROM block starts only when the DDR3 side can take the first read
   assign block_go = state == STATE_FILL_SLOT && is_block && (!is_rom || ddr3_ready);

   always_comb begin
      case (cfg_typ)
         CONFIG_BIOS:       fill_typ = SLOT_TYP_ROM;
         CONFIG_RAM:        fill_typ = SLOT_TYP_RAM;
         CONFIG_RAM_MAPPER: fill_typ = SLOT_TYP_MSX2_RAM;
         CONFIG_MIRROR:     fill_typ = ref_typ;
         default:           fill_typ = SLOT_TYP_EMPTY;
      endcase
   end

   assign fill_block_id = is_mirror ? ref_block_id : cur_block_id;

   assign busy      = state != STATE_WAIT;
   assign ddr3_addr = cfg_store_addr + ddr3_addr_t'(count_value);

   // the held byte goes out in the first cycle the SDRAM accepts it
   assign sdram_we       = wr_pending && sdram_ready;
   assign blk_write_step = sdram_we;

   assign slot_clear  = state == STATE_INIT_SLOT && !count_last;
   assign count_step  = slot_clear || sdram_we;
   assign count_clear = (state == STATE_WAIT && update_request) || block_go;
   assign slot_fill   = block_go || (state == STATE_FILL_SLOT && is_mirror);
   assign blk_start   = block_go;

   always_ff @(posedge clk) begin
      if (rst) begin
         state            <= STATE_WAIT;
         update_ack       <= 1'b0;
         ddr3_rd          <= 1'b0;
         rd_wait          <= 1'b0;
         wr_pending       <= 1'b0;
         cfg_index        <= '0;
         ram_mapper_count <= '0;
      end else begin
         update_ack <= 1'b0;
         ddr3_rd    <= 1'b0;
         if (sdram_we) wr_pending <= 1'b0;
         case (state)
            STATE_WAIT: begin
               if (update_request) begin
                  update_ack <= 1'b1;
                  cfg_index  <= '0;
                  state      <= STATE_INIT_SLOT;
               end
            end
            STATE_INIT_SLOT: begin
               if (count_last) state <= STATE_FILL_SLOT;
            end
            STATE_FILL_SLOT: begin
               if (block_go) begin
                  state <= STATE_UPLOAD;
                  if (is_rom) begin
                     ddr3_rd <= 1'b1;
                     rd_wait <= 1'b1;
                  end
                  if (cfg_typ == CONFIG_RAM_MAPPER) ram_mapper_count <= cfg_block_count;
               end else if (!is_block) begin
                  state <= STATE_FILL_NEXT;
               end
            end
            STATE_UPLOAD: begin
               if (rd_wait) begin
                  // ready returning high after the strobe means the byte is there
                  if (ddr3_ready && !ddr3_rd) begin
                     sdram_din  <= ddr3_dout;
                     wr_pending <= 1'b1;
                     rd_wait    <= 1'b0;
                  end
               end else if (!wr_pending) begin
                  if (count_last) begin
                     state <= STATE_FILL_NEXT;
                  end else if (!is_rom) begin
                     sdram_din  <= 8'h00;
                     wr_pending <= 1'b1;
                  end else if (ddr3_ready) begin
                     ddr3_rd <= 1'b1;
                     rd_wait <= 1'b1;
                  end
               end
            end
            STATE_FILL_NEXT: begin
               if (cfg_index == cfg_index_t'(max_config - 1)) begin
                  state <= STATE_WAIT;
               end else begin
                  cfg_index <= cfg_index + 1'b1;
                  state     <= STATE_FILL_SLOT;
               end
            end
            default: state <= STATE_WAIT;
         endcase
      end
   end

endmodule

/* verilog/upload_ram.sv */
`timescale 1ns/1ps

module upload_ram #(
   parameter int max_config = layout_pkg::max_config,
   parameter int block_bits = 14
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     update_request,
   output logic                     update_ack,
   output logic                     busy,
   output layout_pkg::cfg_index_t   cfg_index,
   input  layout_pkg::config_typ_t  cfg_typ,
   input  slot_pkg::slot_sel_t      cfg_slot,
   input  slot_pkg::slot_sel_t      cfg_subslot,
   input  slot_pkg::slot_sel_t      cfg_page,
   input  slot_pkg::slot_sel_t      cfg_ref_page,
   input  layout_pkg::block_count_t cfg_block_count,
   input  layout_pkg::ddr3_addr_t   cfg_store_addr,
   input  logic                     ddr3_ready,
   output logic                     ddr3_rd,
   output layout_pkg::ddr3_addr_t   ddr3_addr,
   input  logic [7:0]               ddr3_dout,
   input  logic                     sdram_ready,
   output logic                     sdram_we,
   output slot_pkg::sdram_addr_t    sdram_addr,
   output logic [7:0]               sdram_din,
   output layout_pkg::block_count_t ram_mapper_count,
   input  slot_pkg::slot_sel_t      rd_slot,
   input  slot_pkg::slot_sel_t      rd_subslot,
   input  slot_pkg::slot_sel_t      rd_page,
   output slot_pkg::slot_typ_t      rd_typ,
   output slot_pkg::block_id_t      rd_block_id,
   output slot_pkg::slot_sel_t      rd_offset,
   output logic                     rd_init,
   output slot_pkg::slot_typ_t      rd_slot_typ,
   input  slot_pkg::block_id_t      blk_rd_id,
   output layout_pkg::block_count_t blk_rd_count,
   output slot_pkg::sdram_addr_t    blk_rd_offset
);
   import layout_pkg::*;
   import slot_pkg::*;

   block_count_t count_limit;
   logic         count_clear;
   logic         count_step;
   logic         count_last;
   logic [23:0]  count_value;
   logic         slot_clear;
   logic         slot_fill;
   slot_typ_t    fill_typ;
   block_id_t    fill_block_id;
   block_id_t    ref_block_id;
   slot_typ_t    ref_typ;
   logic         blk_start;
   logic         blk_write_step;
   block_id_t    cur_block_id;

   // the counter is cleared for the slot-map sweep while still idle
   assign count_limit = busy ? cfg_block_count : '0;

   upload_fsm #(
      .max_config(max_config)
   ) u_fsm (
      .*
   );

   byte_counter #(
      .block_bits(block_bits)
   ) u_counter (
      .*
   );

   slot_table u_slots (
      .*,
      .clear_index(count_value[5:0]),
      .fill_slot(cfg_slot),
      .fill_subslot(cfg_subslot),
      .fill_page(cfg_page),
      .fill_count(cfg_block_count),
      .ref_page(cfg_ref_page)
   );

   block_table u_blocks (
      .*,
      .blk_clear(slot_clear),
      .blk_count(cfg_block_count),
      .write_addr(sdram_addr),
      .rd_id(blk_rd_id),
      .rd_count(blk_rd_count),
      .rd_offset(blk_rd_offset)
   );

endmodule
